//--- verilog/board_io_pkg.sv
package board_io_pkg;

    // board dimensions
    localparam int n_switches  = 10;
    localparam int n_buttons   = 2;
    localparam int n_red_leds  = 10;
    localparam int n_digits    = 6;
    localparam int hex_width   = 4 * n_digits;

    // bus widths, byte address covers eight word registers
    localparam int wb_adr_w    = 5;
    localparam int wb_data_w   = 32;

    // master to slave request
    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [wb_adr_w-1:0]  adr;
        logic [wb_data_w-1:0] dat;
    } wb_req_t;

    // slave to master response
    typedef struct packed {
        logic                 ack;
        logic [wb_data_w-1:0] dat;
    } wb_rsp_t;

    // debounced board inputs, all active high
    typedef struct packed {
        logic [n_switches-1:0] sw;
        logic [n_buttons-1:0]  btn;
    } board_in_t;

    // active-low segments, bit 0 is a and bit 6 is g
    typedef logic [6:0] seg_pattern_t;

    // register map, byte offsets
    localparam logic [wb_adr_w-1:0] reg_switches   = 5'h00;
    localparam logic [wb_adr_w-1:0] reg_buttons    = 5'h04;
    localparam logic [wb_adr_w-1:0] reg_red_leds   = 5'h08;
    localparam logic [wb_adr_w-1:0] reg_hex_value  = 5'h0C;
    localparam logic [wb_adr_w-1:0] reg_digit_mask = 5'h10;

    // values after reset
    localparam logic [n_red_leds-1:0] red_leds_reset   = '0;
    localparam logic [hex_width-1:0]  hex_value_reset  = '0;
    localparam logic [n_digits-1:0]   digit_mask_reset = '1;

endpackage

//--- verilog/input_sync_debounce.sv
module input_sync_debounce
    import board_io_pkg::*;
#(
    parameter int DEBOUNCE_CYCLES = 500000
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [n_switches-1:0] sw,
    input  logic [n_buttons-1:0]  key,
    output board_in_t             board_in
);

    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

    logic [n_switches-1:0] sw_meta;
    logic [n_switches-1:0] sw_sync;
    logic [n_buttons-1:0]  key_meta;
    logic [n_buttons-1:0]  key_sync;

    board_in_t  sync_vec;
    board_in_t  sync_last;
    board_in_t  accepted;
    logic [CNT_W-1:0] stable_cnt;

    // two-flop synchronizers, keys rest high when released
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sw_meta  <= '0;
            sw_sync  <= '0;
            key_meta <= '1;
            key_sync <= '1;
        end else begin
            sw_meta  <= sw;
            sw_sync  <= sw_meta;
            key_meta <= key;
            key_sync <= key_meta;
        end
    end

    // keys become active high here
    assign sync_vec = '{sw: sw_sync, btn: ~key_sync};

    // shared counter, restarts on any change or when back at the accepted value
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sync_last  <= '0;
            accepted   <= '0;
            stable_cnt <= '0;
        end else begin
            sync_last <= sync_vec;
            if (sync_vec == accepted || sync_vec != sync_last) begin
                stable_cnt <= '0;
            end else if (stable_cnt == CNT_W'(DEBOUNCE_CYCLES - 2)) begin
                // stable for DEBOUNCE_CYCLES cycles, take whole vector
                accepted   <= sync_vec;
                stable_cnt <= '0;
            end else begin
                stable_cnt <= stable_cnt + 1'b1;
            end
        end
    end

    assign board_in = accepted;

endmodule

//--- verilog/io_register_bank.sv
module io_register_bank
    import board_io_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  wb_req_t               wb_req,
    output wb_rsp_t               wb_rsp,
    input  board_in_t             board_in,
    output logic [n_red_leds-1:0] red_leds,
    output logic [hex_width-1:0]  hex_value,
    output logic [n_digits-1:0]   digit_mask
);

    logic                 ack_q;
    logic [wb_data_w-1:0] rdata_q;
    logic [wb_data_w-1:0] rdata_mux;
    logic                 req_valid;
    logic [wb_adr_w-3:0]  word_adr;

    // new request only while ack is low, so one ack per request
    assign req_valid = wb_req.cyc && wb_req.stb && !ack_q;

    // byte lanes unused, decode on the word index
    assign word_adr = wb_req.adr[wb_adr_w-1:2];

    // read mux, unmapped words read as zero
    always_comb begin
        rdata_mux = '0;
        case (word_adr)
            reg_switches[wb_adr_w-1:2]: begin
                rdata_mux = wb_data_w'(board_in.sw);
            end
            reg_buttons[wb_adr_w-1:2]: begin
                rdata_mux = wb_data_w'(board_in.btn);
            end
            reg_red_leds[wb_adr_w-1:2]: begin
                rdata_mux = wb_data_w'(red_leds);
            end
            reg_hex_value[wb_adr_w-1:2]: begin
                rdata_mux = wb_data_w'(hex_value);
            end
            reg_digit_mask[wb_adr_w-1:2]: begin
                rdata_mux = wb_data_w'(digit_mask);
            end
            default: begin
                rdata_mux = '0;
            end
        endcase
    end

    // ack and writable registers
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack_q      <= 1'b0;
            red_leds   <= red_leds_reset;
            hex_value  <= hex_value_reset;
            digit_mask <= digit_mask_reset;
        end else begin
            ack_q <= req_valid;
            if (req_valid && wb_req.we) begin
                case (word_adr)
                    reg_red_leds[wb_adr_w-1:2]: begin
                        red_leds <= wb_req.dat[n_red_leds-1:0];
                    end
                    reg_hex_value[wb_adr_w-1:2]: begin
                        hex_value <= wb_req.dat[hex_width-1:0];
                    end
                    reg_digit_mask[wb_adr_w-1:2]: begin
                        digit_mask <= wb_req.dat[n_digits-1:0];
                    end
                    default: begin
                        // read-only or unmapped, write dropped
                    end
                endcase
            end
        end
    end

    // read data captured alongside ack
    always_ff @(posedge clk) begin
        if (req_valid) begin
            rdata_q <= rdata_mux;
        end
    end

    assign wb_rsp = '{ack: ack_q, dat: rdata_q};

endmodule

//--- verilog/seven_segment_digit.sv
module seven_segment_digit
    import board_io_pkg::*;
(
    input  logic [3:0]   nibble,
    input  logic         blank,
    output seg_pattern_t seg
);

    seg_pattern_t glyph;

    // patterns written as g..a, low means lit
    always_comb begin
        case (nibble)
            4'h0: glyph = 7'b1000000;
            4'h1: glyph = 7'b1111001;
            4'h2: glyph = 7'b0100100;
            4'h3: glyph = 7'b0110000;
            4'h4: glyph = 7'b0011001;
            4'h5: glyph = 7'b0010010;
            4'h6: glyph = 7'b0000010;
            4'h7: glyph = 7'b1111000;
            4'h8: glyph = 7'b0000000;
            4'h9: glyph = 7'b0010000;
            4'hA: glyph = 7'b0001000;
            4'hB: glyph = 7'b0000011;   // lowercase b
            4'hC: glyph = 7'b1000110;
            4'hD: glyph = 7'b0100001;   // lowercase d
            4'hE: glyph = 7'b0000110;
            4'hF: glyph = 7'b0001110;
            default: glyph = 7'b1111111;
        endcase
    end

    // all segments dark when blanked
    assign seg = blank ? 7'b1111111 : glyph;

endmodule

//--- verilog/hex_display_driver.sv
module hex_display_driver
    import board_io_pkg::*;
(
    input  logic [hex_width-1:0] hex_value,
    input  logic [n_digits-1:0]  digit_mask,
    output logic [7:0]           hex0,
    output logic [7:0]           hex1,
    output logic [7:0]           hex2,
    output logic [7:0]           hex3,
    output logic [7:0]           hex4,
    output logic [7:0]           hex5
);

    seg_pattern_t seg [n_digits];

    // digit n shows nibble n, blanked when its mask bit is clear
    seven_segment_digit digit_0 (
        .nibble (hex_value[3:0]),   .blank (!digit_mask[0]), .seg (seg[0])
    );
    seven_segment_digit digit_1 (
        .nibble (hex_value[7:4]),   .blank (!digit_mask[1]), .seg (seg[1])
    );
    seven_segment_digit digit_2 (
        .nibble (hex_value[11:8]),  .blank (!digit_mask[2]), .seg (seg[2])
    );
    seven_segment_digit digit_3 (
        .nibble (hex_value[15:12]), .blank (!digit_mask[3]), .seg (seg[3])
    );
    seven_segment_digit digit_4 (
        .nibble (hex_value[19:16]), .blank (!digit_mask[4]), .seg (seg[4])
    );
    seven_segment_digit digit_5 (
        .nibble (hex_value[23:20]), .blank (!digit_mask[5]), .seg (seg[5])
    );

    // decimal points stay dark
    assign hex0 = {1'b1, seg[0]};
    assign hex1 = {1'b1, seg[1]};
    assign hex2 = {1'b1, seg[2]};
    assign hex3 = {1'b1, seg[3]};
    assign hex4 = {1'b1, seg[4]};
    assign hex5 = {1'b1, seg[5]};

endmodule

//--- verilog/de10_lite_io.sv
module de10_lite_io
    import board_io_pkg::*;
#(
    parameter int DEBOUNCE_CYCLES = 500000
) (
    input  logic                  clk,
    input  logic                  rst_n,

    input  logic [n_switches-1:0] sw,
    input  logic [n_buttons-1:0]  key,

    input  wb_req_t               wb_req,
    output wb_rsp_t               wb_rsp,

    output logic [7:0]            hex0,
    output logic [7:0]            hex1,
    output logic [7:0]            hex2,
    output logic [7:0]            hex3,
    output logic [7:0]            hex4,
    output logic [7:0]            hex5,
    output logic [n_red_leds-1:0] ledr
);

    board_in_t              board_in;
    logic [hex_width-1:0]   hex_value;
    logic [n_digits-1:0]    digit_mask;

    // raw pins to clean active-high inputs
    input_sync_debounce #(
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) input_side (
        .clk      (clk),
        .rst_n    (rst_n),
        .sw       (sw),
        .key      (key),
        .board_in (board_in)
    );

    // bus-visible registers, leds straight to the pins
    io_register_bank reg_bank (
        .clk        (clk),
        .rst_n      (rst_n),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .board_in   (board_in),
        .red_leds   (ledr),
        .hex_value  (hex_value),
        .digit_mask (digit_mask)
    );

    hex_display_driver output_side (
        .hex_value  (hex_value),
        .digit_mask (digit_mask),
        .hex0       (hex0),
        .hex1       (hex1),
        .hex2       (hex2),
        .hex3       (hex3),
        .hex4       (hex4),
        .hex5       (hex5)
    );

endmodule

//--- testbench/tb_de10_lite_io.sv
module tb_de10_lite_io
    import board_io_pkg::*;
();

    localparam int clk_period      = 10;
    localparam int debounce_cycles = 8;
    localparam int n_led           = 8;
    localparam int n_hex           = 9;
    localparam int n_mask          = 8;
    localparam int n_rounds        = 4;
    localparam int txn_cycles      = 2;
    // rough cycle budget of every test plus reset
    localparam int run_cycles = 4 + 5 * txn_cycles
        + (n_led + n_hex + n_mask + 1) * 2 * txn_cycles
        + 2 * (4 * debounce_cycles)
        + n_rounds * (debounce_cycles + 4 + 2 * txn_cycles)
        + 9 * txn_cycles;
    localparam int margin_cycles   = 200;

    logic                  clk;
    logic                  rst_n;
    logic [n_switches-1:0] sw;
    logic [n_buttons-1:0]  key;
    wb_req_t               wb_req;
    wb_rsp_t               wb_rsp;
    logic [7:0]            hex_out [n_digits];
    logic [n_red_leds-1:0] ledr;

    // model of the writable registers
    logic [n_red_leds-1:0] exp_leds;
    logic [hex_width-1:0]  exp_hex;
    logic [n_digits-1:0]   exp_mask;
    integer                seed;
    logic                  prev_new_req;
    logic                  prev_ack;

    de10_lite_io #(
        .DEBOUNCE_CYCLES (debounce_cycles)
    ) dut0 (
        .clk    (clk),
        .rst_n  (rst_n),
        .sw     (sw),
        .key    (key),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .hex0   (hex_out[0]),
        .hex1   (hex_out[1]),
        .hex2   (hex_out[2]),
        .hex3   (hex_out[3]),
        .hex4   (hex_out[4]),
        .hex5   (hex_out[5]),
        .ledr   (ledr)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "run stopped after the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else
            fail_run($sformatf("ERR %s: expected 0x%0h, actual 0x%0h", name, expected, actual));
    endtask

    // lit segments written g..a, pins are active low with dp dark
    function automatic logic [7:0] expected_digit(input logic [3:0] nib, input logic enabled);
        logic [6:0] lit;
        case (nib)
            4'h0: lit = 7'b0111111;
            4'h1: lit = 7'b0000110;
            4'h2: lit = 7'b1011011;
            4'h3: lit = 7'b1001111;
            4'h4: lit = 7'b1100110;
            4'h5: lit = 7'b1101101;
            4'h6: lit = 7'b1111101;
            4'h7: lit = 7'b0000111;
            4'h8: lit = 7'b1111111;
            4'h9: lit = 7'b1101111;
            4'hA: lit = 7'b1110111;
            4'hB: lit = 7'b1111100;
            4'hC: lit = 7'b0111001;
            4'hD: lit = 7'b1011110;
            4'hE: lit = 7'b1111001;
            default: lit = 7'b1110001;
        endcase
        if (!enabled) begin
            lit = '0;
        end
        return {1'b1, ~lit};
    endfunction

    task automatic check_display(input string name);
        for (int n = 0; n < n_digits; n++) begin
            check_value($sformatf("%s digit %0d", name, n),
                        expected_digit(exp_hex[4*n +: 4], exp_mask[n]), hex_out[n]);
        end
        check_value({name, " ledr"}, exp_leds, ledr);
    endtask

    // called and left at 1 time unit after a rising edge
    task automatic bus_cycle(input logic we, input logic [wb_adr_w-1:0] adr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        waited = 0;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdata};
        do begin
            @(posedge clk);
            #1;
            waited++;
        end while (!wb_rsp.ack && waited < 4);
        assert (wb_rsp.ack) else
            fail_run($sformatf("no ack for the bus request at offset 0x%0h", adr));
        rdata = wb_rsp.dat;
        wb_req = '0;
        @(posedge clk);
        #1;
    endtask

    task automatic wb_write(input logic [wb_adr_w-1:0] adr, input logic [31:0] data);
        logic [31:0] ignored;
        bus_cycle(1'b1, adr, data, ignored);
    endtask

    task automatic wb_read(input logic [wb_adr_w-1:0] adr, output logic [31:0] data);
        bus_cycle(1'b0, adr, 32'h0, data);
    endtask

    task automatic read_and_check(input string name, input logic [wb_adr_w-1:0] adr,
                                  input logic [31:0] expected);
        logic [31:0] rdata;
        wb_read(adr, rdata);
        check_value(name, expected, rdata);
    endtask

    task automatic test_reset_state();
        exp_leds = '0;
        exp_hex  = '0;
        exp_mask = 6'h3f;
        check_display("reset");
        read_and_check("reset led reg", reg_red_leds, 32'h0);
        read_and_check("reset hex reg", reg_hex_value, 32'h0);
        read_and_check("reset mask reg", reg_digit_mask, 32'h3f);
        read_and_check("reset switches", reg_switches, 32'h0);
        read_and_check("reset buttons", reg_buttons, 32'h0);
    endtask

    task automatic test_led_register();
        logic [31:0] data;
        repeat (n_led) begin
            data = $random(seed);
            wb_write(reg_red_leds, data);
            exp_leds = data[n_red_leds-1:0];
            check_value("led output", exp_leds, ledr);
            read_and_check("led readback", reg_red_leds, exp_leds);
        end
    endtask

    task automatic test_hex_decoding();
        logic [31:0] data;
        for (int i = 0; i < n_hex; i++) begin
            // first three words walk all sixteen glyphs
            case (i)
                0: data = 32'h00543210;
                1: data = 32'h00ba9876;
                2: data = 32'h00fedcba;
                default: data = $random(seed);
            endcase
            wb_write(reg_hex_value, data);
            exp_hex = data[hex_width-1:0];
            check_display("hex decode");
            read_and_check("hex readback", reg_hex_value, exp_hex);
        end
    endtask

    task automatic test_digit_blanking();
        logic [31:0] data;
        data = $random(seed);
        wb_write(reg_hex_value, data);
        exp_hex = data[hex_width-1:0];
        for (int i = 0; i < n_mask; i++) begin
            data = (i == 0) ? 32'h0 : $random(seed);
            wb_write(reg_digit_mask, data);
            exp_mask = data[n_digits-1:0];
            check_display("blanking");
            read_and_check("mask readback", reg_digit_mask, exp_mask);
        end
    endtask

    // short pulse on the raw pins while the bus keeps polling
    task automatic pulse_inputs(input logic [n_switches-1:0] sw_val,
                                input logic [n_buttons-1:0] key_val);
        logic [n_switches-1:0] base_sw;
        logic [n_buttons-1:0]  base_key;
        logic [n_buttons-1:0]  base_btn;
        base_sw  = sw;
        base_key = key;
        base_btn = ~key;
        fork
            begin
                sw  = sw_val;
                key = key_val;
                repeat (debounce_cycles - 1) begin
                    @(posedge clk);
                    #1;
                end
                sw  = base_sw;
                key = base_key;
            end
            begin
                repeat (debounce_cycles) begin
                    read_and_check("glitch switches", reg_switches, base_sw);
                    read_and_check("glitch buttons", reg_buttons, base_btn);
                end
            end
        join
    endtask

    task automatic test_debounce();
        logic [31:0]          data;
        logic [n_buttons-1:0] exp_btn;
        data = $random(seed);
        pulse_inputs(data[n_switches-1:0] | 10'h1, key);
        pulse_inputs(sw, 2'b00);
        repeat (n_rounds) begin
            data = $random(seed);
            sw  = data[n_switches-1:0];
            key = data[n_switches +: n_buttons];
            // pressed keys read as ones
            exp_btn = ~key;
            repeat (debounce_cycles + 4) begin
                @(posedge clk);
                #1;
            end
            read_and_check("held switches", reg_switches, sw);
            read_and_check("held buttons", reg_buttons, exp_btn);
        end
    endtask

    task automatic test_unmapped();
        for (int adr = 5'h14; adr <= 5'h1c; adr += 4) begin
            wb_write(adr[wb_adr_w-1:0], $random(seed));
            read_and_check($sformatf("unmapped 0x%0h", adr), adr[wb_adr_w-1:0], 32'h0);
        end
        read_and_check("led after unmapped", reg_red_leds, exp_leds);
        read_and_check("hex after unmapped", reg_hex_value, exp_hex);
        read_and_check("mask after unmapped", reg_digit_mask, exp_mask);
        check_display("after unmapped");
    endtask

    // one ack per request, exactly one cycle after it is presented
    always @(negedge clk) begin
        if (rst_n) begin
            assert (!(wb_rsp.ack && prev_ack)) else
                fail_run("ack was high for two cycles in a row");
            assert (wb_rsp.ack == prev_new_req) else
                fail_run(prev_new_req ? "ack did not come one cycle after the request"
                                      : "ack was raised without a request");
        end
        prev_ack     = wb_rsp.ack;
        prev_new_req = rst_n && wb_req.cyc && wb_req.stb && !wb_rsp.ack;
    end

    initial begin
        #((run_cycles + margin_cycles) * clk_period);
        fail_run("timeout, the test sequence did not finish in time");
    end

    initial begin
        seed         = 18;
        rst_n        = 1'b0;
        sw           = '0;
        key          = '1;
        wb_req       = '0;
        prev_new_req = 1'b0;
        prev_ack     = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_reset_state();
        test_led_register();
        test_hex_decoding();
        test_digit_blanking();
        test_debounce();
        test_unmapped();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- vlog.f
verilog/board_io_pkg.sv
verilog/input_sync_debounce.sv
verilog/io_register_bank.sv
verilog/seven_segment_digit.sv
verilog/hex_display_driver.sv
verilog/de10_lite_io.sv
testbench/tb_de10_lite_io.sv

//--- Bender.yml
package:
  name: de10_lite_io

sources:
  # shared package first
  - verilog/board_io_pkg.sv

  # leaf blocks
  - verilog/input_sync_debounce.sv
  - verilog/io_register_bank.sv
  - verilog/seven_segment_digit.sv
  - verilog/hex_display_driver.sv

  # top level
  - verilog/de10_lite_io.sv

  # testbench
  - target: test
    files:
      - testbench/tb_de10_lite_io.sv
